// File: vlane_pkg.sv
// LANE_NUM must be a multiple of LANE_GROUP and sew values above SEW_32 are treated as 32 bit
package vlane_pkg;

   localparam int LANE_GROUP = 4;            // Lanes spanned by one 32-bit element

   typedef logic [31:0] word_t;

   typedef enum logic [1:0]
   {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } elem_width_e;

   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   typedef enum logic [1:0]
   {
      OP2_VECTOR = 2'd0,
      OP2_SCALAR = 2'd1,
      OP2_IMM    = 2'd2
   } op2_src_e;

   // Issue word as it travels down the delay line
   typedef struct packed
   {
      alu_op_e     opcode;
      elem_width_e sew;
      logic        use_scalar;                // Operand b from scalar field
      word_t       scalar;                    // Scalar or sign-extended immediate
   } ctrl_t;

   typedef word_t [LANE_GROUP-1:0] group_t;

   // Lanes per element
   function automatic int sew_group(elem_width_e sew);
      case (sew)
         SEW_8:   return 1;
         SEW_16:  return 2;
         default: return 4;
      endcase
   endfunction

   function automatic word_t sew_mask(elem_width_e sew);
      case (sew)
         SEW_8:   return 32'h0000_00ff;
         SEW_16:  return 32'h0000_ffff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   // Byte transpose inside one group of four lanes
   // Lane base+i byte k takes lane base+k byte i, so the same map packs and scatters
   function automatic group_t byte_transpose(group_t src, elem_width_e sew);
      group_t dst;
      int     grp;
      int     pos;
      int     base;
      dst = '0;                               // Bytes at or above the group size stay zero
      grp = sew_group(sew);
      for (int j = 0; j < LANE_GROUP; j++)
      begin
         pos  = j % grp;                      // Element slot in its subgroup
         base = j - pos;
         for (int k = 0; k < LANE_GROUP; k++)
         begin
            if (k < grp)
               dst[j][8*k +: 8] = src[base + k][8*pos +: 8];
         end
      end
      return dst;
   endfunction

endpackage

// File: aligned_ctrl_if.sv
// Control as seen VRF_DELAY cycles after issue; clk_i and rst_i come from the cluster
`timescale 1ns/1ps

interface aligned_ctrl_if
   import vlane_pkg::*;
(
   input logic clk_i,
   input logic rst_i
);

   logic        valid;
   alu_op_e     opcode;
   elem_width_e sew;
   logic        use_scalar;
   word_t       scalar;

   modport src (output valid, output opcode, output sew, output use_scalar, output scalar);

   // Sink also gets the clock and reset for its checks
   modport dst (input clk_i, input rst_i, input valid, input opcode, input sew,
                input use_scalar, input scalar);

endinterface

// File: issue_decode.sv
// Combinational decode; scalar_i and imm_i are ignored for OP2_VECTOR and sew_i must be legal
`timescale 1ns/1ps

module issue_decode
   import vlane_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        issue_valid_i,
   input  alu_op_e     opcode_i,
   input  elem_width_e sew_i,
   input  op2_src_e    op2_src_i,
   input  word_t       scalar_i,
   input  logic [4:0]  imm_i,
   output logic        issue_valid_o,
   output ctrl_t       ctrl_o
);

   assign issue_valid_o = issue_valid_i;

   ////////////////////////////////////////
   // Operand b source resolution
   ////////////////////////////////////////

   always_comb
   begin
      ctrl_o.opcode = opcode_i;
      ctrl_o.sew    = sew_i;
      case (op2_src_i)
         OP2_SCALAR:
         begin
            ctrl_o.use_scalar = 1'b1;
            ctrl_o.scalar     = scalar_i;
         end
         OP2_IMM:
         begin
            ctrl_o.use_scalar = 1'b1;
            ctrl_o.scalar     = {{27{imm_i[4]}}, imm_i}; // Sign extend simm5
         end
         default:
         begin
            // Vector operand, scalar field unused
            ctrl_o.use_scalar = 1'b0;
            ctrl_o.scalar     = '0;
         end
      endcase
   end

   // Illegal width would mispack lanes all the way down to the scatter
   a_legal_sew : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      issue_valid_i |-> (sew_i inside {SEW_8, SEW_16, SEW_32})
   );

endmodule

// File: ctrl_delay_line.sv
// Fixed latency of VRF_DELAY cycles (at least 1), a new word may enter every cycle, no stall
`timescale 1ns/1ps

module ctrl_delay_line
   import vlane_pkg::*;
#(
   parameter int VRF_DELAY = 3
)
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        issue_valid_i,
   input  ctrl_t       ctrl_i,
   aligned_ctrl_if.src aligned
);

   logic [VRF_DELAY-1:0] valid_q;
   ctrl_t                ctrl_q [VRF_DELAY];

   ////////////////////////////////////////
   // Shift stages, one issue per stage
   ////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         valid_q <= '0;
         for (int s = 0; s < VRF_DELAY; s++)
            ctrl_q[s] <= '0;
      end
      else
      begin
         for (int s = VRF_DELAY - 1; s > 0; s--)
         begin
            valid_q[s] <= valid_q[s-1];
            ctrl_q[s]  <= ctrl_q[s-1];
         end
         valid_q[0] <= issue_valid_i;
         ctrl_q[0]  <= ctrl_i;
      end
   end

   // Oldest stage meets the register file data
   assign aligned.valid      = valid_q[VRF_DELAY-1];
   assign aligned.opcode     = ctrl_q[VRF_DELAY-1].opcode;
   assign aligned.sew        = ctrl_q[VRF_DELAY-1].sew;
   assign aligned.use_scalar = ctrl_q[VRF_DELAY-1].use_scalar;
   assign aligned.scalar     = ctrl_q[VRF_DELAY-1].scalar;

endmodule

// File: operand_packer.sv
// Combinational; lane data must arrive on the exact cycle its control leaves the delay line
`timescale 1ns/1ps

interface alu_operand_if
   import vlane_pkg::*;
#(
   parameter int LANE_NUM = 8
);

   logic                 valid;
   alu_op_e              opcode;
   elem_width_e          sew;
   word_t [LANE_NUM-1:0] a;                   // One element per ALU
   word_t [LANE_NUM-1:0] b;

   modport src (output valid, output opcode, output sew, output a, output b);
   modport dst (input valid, input opcode, input sew, input a, input b);

endinterface

module operand_packer
   import vlane_pkg::*;
#(
   parameter int LANE_NUM = 8
)
(
   input  logic                 lane_valid_i,
   input  word_t [LANE_NUM-1:0] vs1_i,
   input  word_t [LANE_NUM-1:0] vs2_i,
   aligned_ctrl_if.dst          aligned,
   alu_operand_if.src           ops
);

   localparam int GROUP_NUM = LANE_NUM / LANE_GROUP;

   word_t [LANE_NUM-1:0] pack_a;
   word_t [LANE_NUM-1:0] pack_b;

   ////////////////////////////////////////
   // Cross-lane gather by element width
   ////////////////////////////////////////

   always_comb
   begin
      for (int g = 0; g < GROUP_NUM; g++)
      begin
         pack_a[g*LANE_GROUP +: LANE_GROUP] =
            byte_transpose(vs1_i[g*LANE_GROUP +: LANE_GROUP], aligned.sew);
         pack_b[g*LANE_GROUP +: LANE_GROUP] =
            byte_transpose(vs2_i[g*LANE_GROUP +: LANE_GROUP], aligned.sew);
      end
   end

   // Operand b select
   always_comb
   begin
      for (int l = 0; l < LANE_NUM; l++)
      begin
         if (aligned.use_scalar)
            ops.b[l] = aligned.scalar & sew_mask(aligned.sew); // Same value for every element
         else
            ops.b[l] = pack_b[l];
      end
   end

   assign ops.a      = pack_a;
   assign ops.valid  = aligned.valid & lane_valid_i;
   assign ops.opcode = aligned.opcode;
   assign ops.sew    = aligned.sew;

   // Register file latency and VRF_DELAY must agree
   a_lane_ctrl_sync : assert property (
      @(posedge aligned.clk_i) disable iff (!aligned.rst_i)
      lane_valid_i == aligned.valid
   );

endmodule

// File: lane_alu_array.sv
// One cycle latency; results are masked to SEW, unknown opcodes give zero
`timescale 1ns/1ps

module lane_alu_array
   import vlane_pkg::*;
#(
   parameter int LANE_NUM = 8
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   alu_operand_if.dst            ops,
   output logic                  res_valid_o,
   output elem_width_e           res_sew_o,
   output word_t [LANE_NUM-1:0]  res_o
);

   word_t [LANE_NUM-1:0] alu_res;

   ////////////////////////////////////////
   // Per-lane ALUs
   ////////////////////////////////////////

   for (genvar l = 0; l < LANE_NUM; l++)
   begin : g_lane
      word_t raw;

      always_comb
      begin
         case (ops.opcode)
            ALU_ADD: raw = ops.a[l] + ops.b[l];
            ALU_SUB: raw = ops.a[l] - ops.b[l]; // Low bits wrap as at element width
            ALU_AND: raw = ops.a[l] & ops.b[l];
            ALU_OR:  raw = ops.a[l] | ops.b[l];
            ALU_XOR: raw = ops.a[l] ^ ops.b[l];
            default: raw = '0;
         endcase
      end

      assign alu_res[l] = raw & sew_mask(ops.sew);
   end

   // Output stage, width travels with the result
   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         res_valid_o <= 1'b0;
         res_sew_o   <= SEW_8;
      end
      else
      begin
         res_valid_o <= ops.valid;
         if (ops.valid)
            res_sew_o <= ops.sew;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (ops.valid)
         res_o <= alu_res;
   end

endmodule

// File: result_unpacker.sv
// One cycle latency; result_o holds its last value while result_valid_o is low
`timescale 1ns/1ps

module result_unpacker
   import vlane_pkg::*;
#(
   parameter int LANE_NUM = 8
)
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 res_valid_i,
   input  elem_width_e          res_sew_i,
   input  word_t [LANE_NUM-1:0] res_i,
   output logic                 result_valid_o,
   output word_t [LANE_NUM-1:0] result_o
);

   localparam int GROUP_NUM = LANE_NUM / LANE_GROUP;

   word_t [LANE_NUM-1:0] scatter;

   ////////////////////////////////////////
   // Result bytes back to source lanes
   ////////////////////////////////////////

   // Inverse of the operand gather
   always_comb
   begin
      for (int g = 0; g < GROUP_NUM; g++)
      begin
         scatter[g*LANE_GROUP +: LANE_GROUP] =
            byte_transpose(res_i[g*LANE_GROUP +: LANE_GROUP], res_sew_i);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         result_valid_o <= 1'b0;
      else
         result_valid_o <= res_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (res_valid_i)
         result_o <= scatter;                 // Upper bytes already zero
   end

endmodule

// File: vlane_alu_cluster.sv
// Lane data must follow each issue by VRF_DELAY cycles; results appear 2 cycles later, no stall
`timescale 1ns/1ps

module vlane_alu_cluster
   import vlane_pkg::*;
#(
   parameter int LANE_NUM  = 8,               // Multiple of LANE_GROUP
   parameter int VRF_DELAY = 3
)
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 issue_valid_i,
   input  alu_op_e              opcode_i,
   input  elem_width_e          sew_i,
   input  op2_src_e             op2_src_i,
   input  word_t                scalar_i,
   input  logic [4:0]           imm_i,
   input  logic                 lane_valid_i,
   input  word_t [LANE_NUM-1:0] vs1_i,
   input  word_t [LANE_NUM-1:0] vs2_i,
   output logic                 result_valid_o,
   output word_t [LANE_NUM-1:0] result_o
);

   logic                 issue_valid;
   ctrl_t                issue_ctrl;
   logic                 res_valid;
   elem_width_e          res_sew;
   word_t [LANE_NUM-1:0] res;

   aligned_ctrl_if aligned_if (.clk_i(clk_i), .rst_i(rst_i));
   alu_operand_if #(.LANE_NUM(LANE_NUM)) ops_if ();

   ////////////////////////////////////////
   // Issue side
   ////////////////////////////////////////

   issue_decode u_decode (
      .clk_i(clk_i), .rst_i(rst_i), .issue_valid_i(issue_valid_i), .opcode_i(opcode_i),
      .sew_i(sew_i), .op2_src_i(op2_src_i), .scalar_i(scalar_i), .imm_i(imm_i),
      .issue_valid_o(issue_valid), .ctrl_o(issue_ctrl)
   );

   ctrl_delay_line #(.VRF_DELAY(VRF_DELAY)) u_delay (
      .clk_i(clk_i), .rst_i(rst_i), .issue_valid_i(issue_valid), .ctrl_i(issue_ctrl),
      .aligned(aligned_if.src)
   );

   ////////////////////////////////////////
   // Lane datapath
   ////////////////////////////////////////

   operand_packer #(.LANE_NUM(LANE_NUM)) u_packer (
      .lane_valid_i(lane_valid_i), .vs1_i(vs1_i), .vs2_i(vs2_i),
      .aligned(aligned_if.dst), .ops(ops_if.src)
   );

   lane_alu_array #(.LANE_NUM(LANE_NUM)) u_alus (
      .clk_i(clk_i), .rst_i(rst_i), .ops(ops_if.dst),
      .res_valid_o(res_valid), .res_sew_o(res_sew), .res_o(res)
   );

   result_unpacker #(.LANE_NUM(LANE_NUM)) u_unpacker (
      .clk_i(clk_i), .rst_i(rst_i), .res_valid_i(res_valid), .res_sew_i(res_sew),
      .res_i(res), .result_valid_o(result_valid_o), .result_o(result_o)
   );

endmodule

// File: tb_vlane_alu_cluster.sv
// Fixed config of 8 lanes and VRF_DELAY 3; random issues with lane data VRF_DELAY cycles later
`timescale 1ns/1ps

module tb_vlane_alu_cluster
   import vlane_pkg::*;
();

   localparam int LANE_NUM       = 8;
   localparam int VRF_DELAY      = 3;
   localparam int RESET_CYCLES   = 4;
   localparam int IDLE_CYCLES    = 6;     // Quiet period before the first issue
   localparam int NUM_ISSUES     = 180;   // 4 passes over every src, width and opcode
   localparam int DRAIN_CYCLES   = 6;
   localparam int TEST_CYCLES    = RESET_CYCLES + IDLE_CYCLES + 2 * NUM_ISSUES + VRF_DELAY
                                   + DRAIN_CYCLES + 4;
   localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

   typedef word_t [LANE_NUM-1:0] lanes_t;

   typedef struct packed
   {
      alu_op_e     opcode;
      elem_width_e sew;
      op2_src_e    src;
      word_t       scalar;
      logic [4:0]  imm;
   } issue_t;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic        issue_valid_i;
   alu_op_e     opcode_i;
   elem_width_e sew_i;
   op2_src_e    op2_src_i;
   word_t       scalar_i;
   logic [4:0]  imm_i;
   logic        lane_valid_i;
   lanes_t      vs1_i;
   lanes_t      vs2_i;
   logic        result_valid_o;
   lanes_t      result_o;

   integer      seed = 32'h666565da;
   issue_t      pend_q [$];              // Issues waiting for their lane data
   int          due_q [$];
   lanes_t      exp_now = '0;            // Model result for the lane data driven now
   lanes_t      exp_res_d1 = '0;
   lanes_t      exp_res_d2 = '0;
   logic        exp_valid_d1 = 1'b0;
   logic        exp_valid_d2 = 1'b0;
   logic        issued_any = 1'b0;
   int          results_seen = 0;
   int          cycle_cnt = 0;

   vlane_alu_cluster #(.LANE_NUM(LANE_NUM), .VRF_DELAY(VRF_DELAY)) DUT (
      .clk_i(clk_i), .rst_i(rst_i), .issue_valid_i(issue_valid_i), .opcode_i(opcode_i),
      .sew_i(sew_i), .op2_src_i(op2_src_i), .scalar_i(scalar_i), .imm_i(imm_i),
      .lane_valid_i(lane_valid_i), .vs1_i(vs1_i), .vs2_i(vs2_i),
      .result_valid_o(result_valid_o), .result_o(result_o)
   );

   always #20 clk_i = ~clk_i;             // 40 ns period

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic lanes_t model_result(issue_t it, lanes_t v1, lanes_t v2);
      lanes_t out;
      word_t  ea;
      word_t  eb;
      word_t  er;
      word_t  mask;
      word_t  s;
      int     g;
      g    = (it.sew == SEW_8) ? 1 : ((it.sew == SEW_16) ? 2 : 4);
      mask = (g == 4) ? 32'hffff_ffff : ((32'd1 << (8 * g)) - 32'd1);
      s    = (it.src == OP2_IMM) ? {{27{it.imm[4]}}, it.imm} : it.scalar;
      out  = '0;
      for (int b = 0; b < LANE_NUM; b += g)
      begin
         for (int i = 0; i < g; i++)
         begin
            ea = '0;
            eb = '0;
            for (int k = 0; k < g; k++)
            begin
               ea[8*k +: 8] = v1[b+k][8*i +: 8]; // Byte i of each lane in the group
               eb[8*k +: 8] = v2[b+k][8*i +: 8];
            end
            if (it.src != OP2_VECTOR)
               eb = s & mask;
            case (it.opcode)
               ALU_ADD: er = ea + eb;
               ALU_SUB: er = ea - eb;
               ALU_AND: er = ea & eb;
               ALU_OR:  er = ea | eb;
               ALU_XOR: er = ea ^ eb;
               default: er = '0;
            endcase
            er = er & mask;
            for (int k = 0; k < g; k++)
               out[b+k][8*i +: 8] = er[8*k +: 8]; // Back to the source lanes
         end
      end
      return out;
   endfunction

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Expected outputs two cycles behind the lane data
   always @(posedge clk_i)
   begin
      exp_valid_d1 <= lane_valid_i;
      exp_valid_d2 <= exp_valid_d1;
      exp_res_d1   <= exp_now;
      exp_res_d2   <= exp_res_d1;
      if (rst_i && result_valid_o)
         results_seen <= results_seen + 1;
   end

   a_quiet_before_issue : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      !issued_any |-> !result_valid_o
   ) else fail_now("Result valid seen before any issue was made");

   a_valid_timing : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      result_valid_o == exp_valid_d2
   ) else fail_now($sformatf("Mismatch result_valid_o: got %h expected %h",
                             $sampled(result_valid_o), $sampled(exp_valid_d2)));

   a_result_data : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      result_valid_o |-> (result_o == exp_res_d2)
   ) else fail_now($sformatf("Mismatch result_o: got %h expected %h",
                             $sampled(result_o), $sampled(exp_res_d2)));

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         fail_now($sformatf("Timeout: test did not finish within %0d cycles", cycle_cnt));
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin
      issue_t     it;
      issue_t     head;
      logic [31:0] rnd;
      logic       last_idle;
      int         n_issued;
      int         slot;
      rst_i         = 1'b0;
      issue_valid_i = 1'b0;
      opcode_i      = ALU_ADD;
      sew_i         = SEW_8;
      op2_src_i     = OP2_VECTOR;
      scalar_i      = '0;
      imm_i         = '0;
      lane_valid_i  = 1'b0;
      vs1_i         = '0;
      vs2_i         = '0;
      last_idle     = 1'b0;
      n_issued      = 0;
      slot          = 0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2 rst_i = 1'b1;
      repeat (IDLE_CYCLES) @(posedge clk_i);

      while (n_issued < NUM_ISSUES || due_q.size() > 0)
      begin
         @(posedge clk_i);
         #2;
         rnd           = $random(seed);
         issue_valid_i = 1'b0;
         if (n_issued < NUM_ISSUES && (last_idle || rnd[1:0] != 2'b00))
         begin
            it.opcode = alu_op_e'(3'(n_issued % 5));
            it.sew    = elem_width_e'(2'((n_issued / 5) % 3));
            it.src    = op2_src_e'(2'((n_issued / 15) % 3));
            it.scalar = $random(seed);
            it.imm    = {n_issued[0], rnd[7:4]}; // Sign alternates per combination
            issue_valid_i = 1'b1;
            opcode_i      = it.opcode;
            sew_i         = it.sew;
            op2_src_i     = it.src;
            scalar_i      = it.scalar;
            imm_i         = it.imm;
            pend_q.push_back(it);
            due_q.push_back(slot + VRF_DELAY);
            issued_any = 1'b1;
            n_issued++;
            last_idle = 1'b0;
         end
         else
            last_idle = 1'b1;

         // Register file data for the oldest issue
         lane_valid_i = 1'b0;
         if (due_q.size() > 0 && due_q[0] == slot)
         begin
            head = pend_q.pop_front();
            void'(due_q.pop_front());
            for (int l = 0; l < LANE_NUM; l++)
            begin
               vs1_i[l] = $random(seed);
               vs2_i[l] = $random(seed);
            end
            lane_valid_i = 1'b1;
            exp_now      = model_result(head, vs1_i, vs2_i);
         end
         slot++;
      end

      @(posedge clk_i);
      #2;
      issue_valid_i = 1'b0;
      lane_valid_i  = 1'b0;
      repeat (DRAIN_CYCLES) @(posedge clk_i);
      #2;
      if (results_seen == NUM_ISSUES)
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
      else
         fail_now($sformatf("Result count wrong: saw %0d results for %0d issues",
                            results_seen, NUM_ISSUES));
   end

endmodule

// File: project.f
vlane_pkg.sv
aligned_ctrl_if.sv
issue_decode.sv
ctrl_delay_line.sv
operand_packer.sv
lane_alu_array.sv
result_unpacker.sv
vlane_alu_cluster.sv
tb_vlane_alu_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_vlane_alu_cluster -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

exit 0
